// File: ts_subsystem.f
ts_cfg_pkg.sv
ts_state_pkg.sv
ext_trg.sv
trig_source_sel.sv
trig_seq_core.sv
measure_arbiter.sv
ts_top.sv
tb_ts_top.sv

// File: Bender.yml
package:
  name: ts_subsystem

sources:
  - ts_cfg_pkg.sv
  - ts_state_pkg.sv
  - ext_trg.sv
  - trig_source_sel.sv
  - trig_seq_core.sv
  - measure_arbiter.sv
  - ts_top.sv
  - target: simulation
    files:
      - tb_ts_top.sv

// File: tb_ts_top.sv
// Runs with N_CH = 2 only; device delays come from a fixed-seed xorshift so every run repeats
`timescale 1ns/1ps

module tb_ts_top;

    import ts_cfg_pkg::*;
    import ts_state_pkg::*;

    localparam int N_CH      = 2;
    localparam int LIMIT_CYC = 2 * 36 * 20 + 600; // About 36 measurements of up to 20 cycles

    logic clk, rst, ext_trigger, measure_start, measure_ready, measure_done;
    logic [N_CH-1:0] ctrl_abort, ctrl_init_immediate, ctrl_init_continuous;
    logic [N_CH-1:0] ctrl_arm_immediate, ctrl_trigger_immediate;
    logic [N_CH-1:0][SRC_W-1:0]   ctrl_arm_source, ctrl_trigger_source;
    logic [N_CH-1:0][COUNT_W-1:0] ctrl_arm_count, ctrl_trigger_count;
    logic [N_CH-1:0] stat_operation_complete, stat_sweeping, stat_waiting_for_arm;
    logic [N_CH-1:0] stat_waiting_for_trigger, stat_measuring;

    int          errors, err_mark, tests_run, tests_failed;
    int          meas_cnt [N_CH]; // Measurements finished per channel
    int          n_start;         // Starts taken by the device model
    logic        dev_active;
    logic [31:0] rng;
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       msg_q [$];

    ts_top #(.N_CH(N_CH), .SYNC_STAGES(2)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Measurements per single initiate, a count of 0 counting as 1
    function automatic int expected_meas(input int arm_n, input int trig_n);
        return ((arm_n < 1) ? 1 : arm_n) * ((trig_n < 1) ? 1 : trig_n);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2; // Drive and sample just after the edge
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s, got %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic post_check(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        msg_q.push_back(what);
        act_q.push_back(got);
        exp_q.push_back(want);
    endtask

    // Queued results are compared mid-cycle
    initial begin : compare_results
        forever begin
            @(negedge clk);
            while (exp_q.size() > 0) begin
                check_value(msg_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    task automatic finish_test(input string name);
        @(negedge clk);
        #1; // After the compare process
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("Test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
        meas_cnt = '{default: 0};
        next_cycle();
    endtask

    task automatic config_channel(input int ch, input int arm_src, input int trig_src,
                                  input int arm_n, input int trig_n);
        ctrl_arm_source[ch]     = SRC_W'(arm_src);
        ctrl_trigger_source[ch] = SRC_W'(trig_src);
        ctrl_arm_count[ch]      = COUNT_W'(arm_n);
        ctrl_trigger_count[ch]  = COUNT_W'(trig_n);
    endtask

    task automatic pulse_init(input logic [N_CH-1:0] mask);
        ctrl_init_immediate = mask;
        next_cycle();
        ctrl_init_immediate = '0;
    endtask

    // Lets the channel leave IDLE, then waits for it to report completion
    task automatic wait_complete(input int ch);
        repeat (2) next_cycle();
        while (!stat_operation_complete[ch]) next_cycle();
    endtask

    // Device model with random ready and done latency; done may share the ready cycle
    initial begin : device_model
        int              d_rdy;
        int              d_done;
        logic [N_CH-1:0] m_done;
        dev_active = 1'b0;
        n_start    = 0;
        rng        = 32'd1805;
        forever begin
            next_cycle();
            if (measure_start) begin
                dev_active = 1'b1;
                n_start++;
                rng    = xorshift(rng);
                d_rdy  = rng % 5;
                rng    = xorshift(rng);
                d_done = rng % 6;
                repeat (d_rdy) next_cycle();
                measure_ready = 1'b1;
                for (int k = 0; k < d_done; k++) begin
                    next_cycle();
                    measure_ready = 1'b0;
                    post_check("measure_start while the device is busy", measure_start, 0);
                end
                measure_done = 1'b1;
                m_done       = stat_measuring;
                next_cycle();
                measure_ready = 1'b0;
                measure_done  = 1'b0;
                // Owner is the channel that stops measuring after done
                for (int c = 0; c < N_CH; c++) begin
                    if (m_done[c] && !stat_measuring[c]) meas_cnt[c]++;
                end
                dev_active = 1'b0;
            end
        end
    end

    initial begin : watchdog
        seq_state_t st0;
        seq_state_t st1;
        repeat (LIMIT_CYC + 8) @(posedge clk);
        st0 = DUT.g_ch[0].u_seq.state;
        st1 = DUT.g_ch[1].u_seq.state;
        $display("Timeout: the run did not finish, channel states %s and %s",
                 st0.name(), st1.name());
        $display("Test failures found");
        $finish;
    end

    initial begin : main_seq
        int cnt_mark;
        int start_mark;
        rst                    = 1'b1;
        ext_trigger            = 1'b0;
        measure_ready          = 1'b0;
        measure_done           = 1'b0;
        ctrl_abort             = '0;
        ctrl_init_immediate    = '0;
        ctrl_init_continuous   = '0;
        ctrl_arm_immediate     = '0;
        ctrl_trigger_immediate = '0;
        ctrl_arm_source        = '0;
        ctrl_trigger_source    = '0;
        ctrl_arm_count         = '0;
        ctrl_trigger_count     = '0;
        errors                 = 0;
        err_mark               = 0;
        tests_run              = 0;
        tests_failed           = 0;
        meas_cnt               = '{default: 0};
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) next_cycle();

        // Immediate sweep on channel 0
        config_channel(0, 1 << SRC_IMMEDIATE, 1 << SRC_IMMEDIATE, 3, 4);
        pulse_init(2'b01);
        wait_complete(0);
        post_check("channel 0 measurements", meas_cnt[0], expected_meas(3, 4));
        repeat (20) begin
            next_cycle();
            post_check("channel 0 stays complete", stat_operation_complete[0], 1);
            post_check("channel 0 not sweeping when complete", stat_sweeping[0], 0);
        end
        post_check("channel 0 extra measurements", meas_cnt[0], expected_meas(3, 4));
        finish_test("immediate sweep");

        // Both channels contend for the device
        config_channel(0, 1 << SRC_IMMEDIATE, 1 << SRC_IMMEDIATE, 2, 3);
        config_channel(1, 1 << SRC_IMMEDIATE, 1 << SRC_IMMEDIATE, 1, 5);
        pulse_init(2'b11);
        wait_complete(0);
        wait_complete(1);
        post_check("channel 0 measurements", meas_cnt[0], expected_meas(2, 3));
        post_check("channel 1 measurements", meas_cnt[1], expected_meas(1, 5));
        finish_test("shared device contention");

        // One rising edge per trigger wait
        config_channel(1, 1 << SRC_IMMEDIATE, 1 << SRC_EXT_RISE, 1, 3);
        pulse_init(2'b10);
        repeat (3) begin
            while (!stat_waiting_for_trigger[1]) next_cycle();
            ext_trigger = 1'b1;
            repeat (4) next_cycle(); // Long enough for the synchronizer
            ext_trigger = 1'b0;
            while (stat_waiting_for_trigger[1]) next_cycle();
            repeat (4) next_cycle();
        end
        wait_complete(1);
        post_check("channel 1 measurements per edge", meas_cnt[1], expected_meas(1, 3));
        finish_test("external rising-edge trigger");

        // Arm only while the line is low
        config_channel(0, 1 << SRC_EXT_LOW, 1 << SRC_IMMEDIATE, 2, 2);
        ext_trigger = 1'b1;
        repeat (5) next_cycle();
        pulse_init(2'b01);
        repeat (30) next_cycle();
        post_check("channel 0 measurements with the line high", meas_cnt[0], 0);
        post_check("channel 0 waiting for arm", stat_waiting_for_arm[0], 1);
        post_check("channel 0 sweeping while waiting for arm", stat_sweeping[0], 1);
        post_check("channel 0 not waiting for trigger", stat_waiting_for_trigger[0], 0);
        ext_trigger = 1'b0;
        wait_complete(0);
        post_check("channel 0 measurements after arm", meas_cnt[0], expected_meas(2, 2));
        finish_test("level-low arm source");

        // Continuous sweeps, then abort
        config_channel(0, 1 << SRC_IMMEDIATE, 1 << SRC_IMMEDIATE, 1, 2);
        ctrl_init_continuous[0] = 1'b1;
        while (meas_cnt[0] <= 2 * expected_meas(1, 2)) next_cycle();
        ctrl_init_continuous[0] = 1'b0;
        ctrl_abort[0]           = 1'b1;
        next_cycle();
        ctrl_abort[0] = 1'b0;
        post_check("channel 0 idle after abort", stat_operation_complete[0], 1);
        while (dev_active) next_cycle(); // A measurement in flight still ends
        cnt_mark   = meas_cnt[0];
        start_mark = n_start;
        repeat (40) next_cycle();
        post_check("channel 0 measurements after abort", meas_cnt[0], cnt_mark);
        post_check("device starts after abort", n_start, start_mark);
        post_check("channel 0 stays idle", stat_operation_complete[0], 1);
        finish_test("continuous mode and abort");

        $display("Done: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: ts_top.sv
// One external trigger line feeds every channel; all channels share one measurement device
`timescale 1ns/1ps

module ts_top #(
    parameter int N_CH        = 2,
    parameter int SYNC_STAGES = 2
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      ext_trigger,
    output logic                                      measure_start,
    input  logic                                      measure_ready,
    input  logic                                      measure_done,
    input  logic [N_CH-1:0]                           ctrl_abort,
    input  logic [N_CH-1:0]                           ctrl_init_immediate,
    input  logic [N_CH-1:0]                           ctrl_init_continuous,
    input  logic [N_CH-1:0]                           ctrl_arm_immediate,
    input  logic [N_CH-1:0]                           ctrl_trigger_immediate,
    input  logic [N_CH-1:0][ts_cfg_pkg::SRC_W-1:0]    ctrl_arm_source,
    input  logic [N_CH-1:0][ts_cfg_pkg::SRC_W-1:0]    ctrl_trigger_source,
    input  logic [N_CH-1:0][ts_cfg_pkg::COUNT_W-1:0]  ctrl_arm_count,
    input  logic [N_CH-1:0][ts_cfg_pkg::COUNT_W-1:0]  ctrl_trigger_count,
    output logic [N_CH-1:0]                           stat_operation_complete,
    output logic [N_CH-1:0]                           stat_sweeping,
    output logic [N_CH-1:0]                           stat_waiting_for_arm,
    output logic [N_CH-1:0]                           stat_waiting_for_trigger,
    output logic [N_CH-1:0]                           stat_measuring
);

    logic            ext_level;
    logic            ext_rise;
    logic            ext_fall;
    logic [N_CH-1:0] arm_event;
    logic [N_CH-1:0] trig_event;
    logic [N_CH-1:0] meas_req;   // Held while a channel waits for the device
    logic [N_CH-1:0] meas_ready;
    logic [N_CH-1:0] meas_done;

    // Shared synchronizer and edge detector
    ext_trg #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_ext_trg (
        .clk        (clk),
        .rst        (rst),
        .ext_trigger(ext_trigger),
        .ext_level  (ext_level),
        .ext_rise   (ext_rise),
        .ext_fall   (ext_fall)
    );

    for (genvar i = 0; i < N_CH; i++) begin : g_ch
        trig_source_sel u_arm_sel (
            .clk      (clk),
            .rst      (rst),
            .immediate(ctrl_arm_immediate[i]),
            .source   (ctrl_arm_source[i]),
            .ext_level(ext_level),
            .ext_rise (ext_rise),
            .ext_fall (ext_fall),
            .event_out(arm_event[i])
        );

        trig_source_sel u_trig_sel (
            .clk      (clk),
            .rst      (rst),
            .immediate(ctrl_trigger_immediate[i]),
            .source   (ctrl_trigger_source[i]),
            .ext_level(ext_level),
            .ext_rise (ext_rise),
            .ext_fall (ext_fall),
            .event_out(trig_event[i])
        );

        trig_seq_core u_seq (
            .clk                     (clk),
            .rst                     (rst),
            .ctrl_abort              (ctrl_abort[i]),
            .ctrl_init_immediate     (ctrl_init_immediate[i]),
            .ctrl_init_continuous    (ctrl_init_continuous[i]),
            .ctrl_arm_count          (ctrl_arm_count[i]),
            .ctrl_trigger_count      (ctrl_trigger_count[i]),
            .arm_event               (arm_event[i]),
            .trig_event              (trig_event[i]),
            .meas_ready              (meas_ready[i]),
            .meas_done               (meas_done[i]),
            .meas_req                (meas_req[i]),
            .stat_operation_complete (stat_operation_complete[i]),
            .stat_sweeping           (stat_sweeping[i]),
            .stat_waiting_for_arm    (stat_waiting_for_arm[i]),
            .stat_waiting_for_trigger(stat_waiting_for_trigger[i]),
            .stat_measuring          (stat_measuring[i])
        );
    end

    measure_arbiter #(
        .N_CH(N_CH)
    ) u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .meas_req     (meas_req),
        .meas_ready   (meas_ready),
        .meas_done    (meas_done),
        .measure_start(measure_start),
        .measure_ready(measure_ready),
        .measure_done (measure_done)
    );

endmodule

// File: measure_arbiter.sv
// No handshake to the device; an owner that drops its request before ready loses the grant
`timescale 1ns/1ps

module measure_arbiter #(
    parameter int N_CH = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [N_CH-1:0] meas_req,
    output logic [N_CH-1:0] meas_ready,
    output logic [N_CH-1:0] meas_done,
    output logic            measure_start,
    input  logic            measure_ready,
    input  logic            measure_done
);

    import ts_state_pkg::*;

    localparam int OWN_W = (N_CH > 1) ? $clog2(N_CH) : 1;

    arb_state_t       state;
    logic [OWN_W-1:0] owner;       // Current or last owner
    logic             ready_seen;  // Device accepted the start
    logic             grant_found;
    logic [OWN_W-1:0] grant_idx;

    // Round-robin search, starting after the last owner
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = owner;
        for (int k = 1; k <= N_CH; k++) begin
            idx = (int'(owner) + k) % N_CH;
            if (!grant_found && meas_req[idx]) begin
                grant_found = 1'b1;
                grant_idx   = OWN_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_FREE;
            owner      <= OWN_W'(N_CH - 1); // Channel 0 wins first
            ready_seen <= 1'b0;
        end else begin
            case (state)
                ARB_FREE: begin
                    if (grant_found) begin
                        state      <= ARB_BUSY;
                        owner      <= grant_idx;
                        ready_seen <= 1'b0;
                    end
                end
                ARB_BUSY: begin
                    if (measure_ready) begin
                        ready_seen <= 1'b1;
                    end
                    // Release after done, or when the owner aborted before ready
                    if (measure_done || (!ready_seen && !meas_req[owner])) begin
                        state <= ARB_FREE;
                    end
                end
                default: state <= ARB_FREE;
            endcase
        end
    end

    // Device pulses reach the owner only
    always_comb begin
        meas_ready = '0;
        meas_done  = '0;
        if (state == ARB_BUSY) begin
            meas_ready[owner] = measure_ready;
            meas_done[owner]  = measure_done;
        end
    end

    assign measure_start = (state == ARB_BUSY) && !ready_seen && meas_req[owner];

endmodule

// File: trig_seq_core.sv
// Events are only consumed in the wait states; an abort mid-measurement leaves the device running
`timescale 1ns/1ps

module trig_seq_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ctrl_abort,
    input  logic                           ctrl_init_immediate,
    input  logic                           ctrl_init_continuous,
    input  logic [ts_cfg_pkg::COUNT_W-1:0] ctrl_arm_count,
    input  logic [ts_cfg_pkg::COUNT_W-1:0] ctrl_trigger_count,
    input  logic                           arm_event,
    input  logic                           trig_event,
    input  logic                           meas_ready,
    input  logic                           meas_done,
    output logic                           meas_req,
    output logic                           stat_operation_complete,
    output logic                           stat_sweeping,
    output logic                           stat_waiting_for_arm,
    output logic                           stat_waiting_for_trigger,
    output logic                           stat_measuring
);

    import ts_cfg_pkg::*;
    import ts_state_pkg::*;

    seq_state_t         state;
    seq_state_t         state_next;
    logic [COUNT_W-1:0] arm_cnt;   // Arms completed in this initiate
    logic [COUNT_W-1:0] trig_cnt;  // Triggers completed in this arm
    logic               arm_hold;  // Next state inside the arm loop
    logic               trig_hold; // Next state inside the trigger loop

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        if (ctrl_abort) begin
            state_next = IDLE;
        end else begin
            case (state)
                RST: begin
                    state_next = IDLE;
                end
                IDLE: begin
                    if (ctrl_init_immediate || ctrl_init_continuous) begin
                        state_next = INIT_DOWN;
                    end
                end
                INIT_DOWN: begin
                    state_next = ARM_DOWN;
                end
                INIT_UP: begin
                    // Continuous mode restarts the sweep
                    state_next = ctrl_init_continuous ? ARM_DOWN : IDLE;
                end
                ARM_DOWN: begin
                    if (arm_event) begin
                        state_next = TRIG_DOWN;
                    end
                end
                ARM_UP: begin
                    state_next = (arm_cnt >= ctrl_arm_count) ? INIT_UP : ARM_DOWN;
                end
                TRIG_DOWN: begin
                    if (trig_event) begin
                        state_next = MEAS_START;
                    end
                end
                TRIG_UP: begin
                    state_next = (trig_cnt >= ctrl_trigger_count) ? ARM_UP : TRIG_DOWN;
                end
                MEAS_START: begin
                    // Ready and done together skip the wait state
                    if (meas_ready) begin
                        state_next = meas_done ? TRIG_UP : MEAS_WAIT;
                    end
                end
                MEAS_WAIT: begin
                    if (meas_done) begin
                        state_next = TRIG_UP;
                    end
                end
                default: begin
                    state_next = RST;
                end
            endcase
        end
    end

    // Loop membership of the next state
    always_comb begin
        trig_hold = (state_next == TRIG_DOWN) || (state_next == MEAS_START) ||
                    (state_next == MEAS_WAIT);
        arm_hold  = trig_hold || (state_next == ARM_DOWN) || (state_next == TRIG_UP);
    end

    // Counters bump on entry to the check state and clear once the loop is left
    always_ff @(posedge clk) begin
        if (rst) begin
            arm_cnt  <= '0;
            trig_cnt <= '0;
        end else begin
            if (state_next == ARM_UP) begin
                arm_cnt <= arm_cnt + 1'b1;
            end else if (!arm_hold) begin
                arm_cnt <= '0;
            end

            if (state_next == TRIG_UP) begin
                trig_cnt <= trig_cnt + 1'b1;
            end else if (!trig_hold) begin
                trig_cnt <= '0;
            end
        end
    end

    // Status and request follow the state being entered
    always_ff @(posedge clk) begin
        if (rst) begin
            meas_req                 <= 1'b0;
            stat_operation_complete  <= 1'b0;
            stat_sweeping            <= 1'b0;
            stat_waiting_for_arm     <= 1'b0;
            stat_waiting_for_trigger <= 1'b0;
            stat_measuring           <= 1'b0;
        end else begin
            meas_req                 <= (state_next == MEAS_START);
            stat_operation_complete  <= (state_next == IDLE);
            stat_sweeping            <= arm_hold || (state_next == ARM_UP);
            stat_waiting_for_arm     <= arm_hold && (state_next != ARM_UP);
            stat_waiting_for_trigger <= (state_next == TRIG_DOWN);
            stat_measuring           <= (state_next == MEAS_START) || (state_next == MEAS_WAIT);
        end
    end

endmodule

// File: trig_source_sel.sv
// Event strobe lags its inputs by one cycle; level sources keep it high while true
`timescale 1ns/1ps

module trig_source_sel (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         immediate,
    input  logic [ts_cfg_pkg::SRC_W-1:0] source,
    input  logic                         ext_level,
    input  logic                         ext_rise,
    input  logic                         ext_fall,
    output logic                         event_out
);

    import ts_cfg_pkg::*;

    logic cond_hit; // Any selected condition true this cycle

    // Masked external conditions
    always_comb begin
        cond_hit = source[SRC_IMMEDIATE];
        if (source[SRC_EXT_RISE] && ext_rise) begin
            cond_hit = 1'b1;
        end
        if (source[SRC_EXT_FALL] && ext_fall) begin
            cond_hit = 1'b1;
        end
        if (source[SRC_EXT_HIGH] && ext_level) begin
            cond_hit = 1'b1;
        end
        if (source[SRC_EXT_LOW] && !ext_level) begin
            cond_hit = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            event_out <= 1'b0;
        end else begin
            event_out <= immediate || cond_hit; // Software strobe bypasses the mask
        end
    end

endmodule

// File: ext_trg.sv
// ext_trigger is asynchronous; pulses shorter than about two clk periods may be missed
`timescale 1ns/1ps

module ext_trg #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic ext_trigger,
    output logic ext_level,
    output logic ext_rise,
    output logic ext_fall
);

    logic [SYNC_STAGES-1:0] sync_ff; // Stage 0 samples the raw line
    logic                   level_d; // Previous synchronized level

    // Plain flip-flop synchronizer chain
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_ff <= '0;
        end else begin
            sync_ff[0] <= ext_trigger;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_ff[s] <= sync_ff[s-1];
            end
        end
    end

    assign ext_level = sync_ff[SYNC_STAGES-1];

    // Edge pulses, one cycle after the level changes
    always_ff @(posedge clk) begin
        if (rst) begin
            level_d  <= 1'b0;
            ext_rise <= 1'b0;
            ext_fall <= 1'b0;
        end else begin
            level_d  <= ext_level;
            ext_rise <= ext_level && !level_d;
            ext_fall <= !ext_level && level_d;
        end
    end

endmodule

// File: ts_state_pkg.sv
// Encodings are internal to the design and may change; compare states by name only
package ts_state_pkg;

    // Per-channel trigger sequence
    typedef enum logic [3:0] {
        RST,        // Leaving reset
        IDLE,       // Waiting for an initiate
        INIT_DOWN,  // Initiated, heading into the arm loop
        INIT_UP,    // Initiated, returning after the arm count
        ARM_DOWN,   // Waiting for an arm event
        ARM_UP,     // Arm count check
        TRIG_DOWN,  // Waiting for a trigger event
        TRIG_UP,    // Trigger count check
        MEAS_START, // Requesting the device, waiting for ready
        MEAS_WAIT   // Device running, waiting for done
    } seq_state_t;

    // Shared device ownership
    typedef enum logic {
        ARB_FREE, // No owner, searching for a requester
        ARB_BUSY  // Device held by one channel until done
    } arb_state_t;

endpackage

// File: ts_cfg_pkg.sv
// Only mask bits 0 and 4 to 7 are decoded; counts are unsigned and a count of 0 acts as 1
package ts_cfg_pkg;

    // Control word widths
    localparam int COUNT_W = 32; // Arm and trigger counts
    localparam int SRC_W   = 32; // Arm and trigger source masks

    // Source mask bit positions, shared by the arm and trigger masks
    localparam int SRC_IMMEDIATE = 0; // Condition is always true
    localparam int SRC_EXT_RISE  = 4; // Rising edge of the synchronized external line
    localparam int SRC_EXT_FALL  = 5; // Falling edge
    localparam int SRC_EXT_HIGH  = 6; // Line currently high
    localparam int SRC_EXT_LOW   = 7; // Line currently low

    // Bits 1 to 3 and 8 upward are reserved

endpackage
